//--- compile.f
+incdir+tests
hdl/fcore_pkg.sv
hdl/input_sequencer.sv
hdl/register_file.sv
hdl/channel_processor.sv
hdl/fcore_complex.sv
tests/fcore_complex_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and searches the log for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module fcore_complex_tb -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vfcore_complex_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TB PASSED" sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1

//--- tests/fcore_model.svh
// LFSR random source, reference model state, result scaling and expected-result queue tasks
`ifndef FCORE_MODEL_SVH
`define FCORE_MODEL_SVH

logic [31:0] lfsr_state = 32'h1d68_6c4e;
fcore_pkg::data_t model_constants [fcore_pkg::N_CONSTANTS] = '{default: '0};
fcore_pkg::data_t model_samples [N_CHANNELS] = '{default: '0};
logic [fcore_pkg::N_CONSTANTS-1:0] model_loaded = '0;
logic model_busy = 1'b0;
int runs_accepted = 0;
int runs_pending = 0;
fcore_pkg::result_t expected_queue [$];

// Taps 32, 22, 2 and 1 give a maximal length sequence
function automatic logic [31:0] lfsr_bits(input int count);
    logic [31:0] value;
    logic feedback;
    value = '0;
    for (int i = 0; i < count; i++) begin
        feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], feedback};
        value = {value[30:0], feedback};
    end
    return value;
endfunction

// Signed product with the gain fraction removed, then the offset, all wrapped to 32 bits
function automatic fcore_pkg::data_t scale_sample(input fcore_pkg::data_t sample_value,
        input fcore_pkg::data_t gain, input fcore_pkg::data_t offset);
    longint product;
    product = longint'(sample_value) * longint'(gain);
    return fcore_pkg::data_t'(product >>> fcore_pkg::FRACTION_BITS) + offset;
endfunction

task automatic queue_run_results();
    fcore_pkg::result_t entry;
    for (int ch = 0; ch < N_CHANNELS; ch++) begin
        entry.channel = fcore_pkg::reg_addr_t'(ch);
        entry.data = scale_sample(model_samples[ch], model_constants[0], model_constants[1]);
        expected_queue.push_back(entry);
    end
endtask

// One clock edge of the input rules, fed with the port values that the DUT sampled
task automatic model_clock_edge(input logic c_valid, input fcore_pkg::const_index_t c_index,
        input fcore_pkg::data_t c_data, input logic s_valid, input fcore_pkg::reg_write_t s,
        input logic start_seen, input logic done_seen);
    if (model_busy) begin
        model_busy = !done_seen;
    end else if (start_seen && (&model_loaded)) begin
        queue_run_results();
        model_busy = 1'b1;
        runs_accepted++;
        runs_pending++;
    end else begin
        if (c_valid) begin
            model_constants[c_index] = c_data;
            model_loaded[c_index] = 1'b1;
        end
        if (s_valid && s.address < N_CHANNELS) begin
            model_samples[int'(s.address)] = s.data;
        end
    end
endtask

`endif

//--- tests/fcore_complex_tb.sv
// Testbench top with clock, reset, stimulus, response checks, timeout and summary
`timescale 1ns/100ps

module fcore_complex_tb;

    localparam int N_CHANNELS = 8;
    localparam int PLANNED_RUNS = 27;
    localparam int CYCLE_LIMIT = 1000 + 40 * PLANNED_RUNS;

    logic core_clock;
    logic reset;
    logic constant_valid;
    fcore_pkg::const_index_t constant_index;
    fcore_pkg::data_t constant_data;
    logic sample_valid;
    fcore_pkg::reg_write_t sample;
    logic start;
    logic result_valid;
    fcore_pkg::result_t result;
    logic done;

    int cycle_count = 0;
    int checks = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int test_errors_start = 0;
    int results_seen = 0;
    int dones_seen = 0;

    `include "fcore_model.svh"

    fcore_complex #(
        .N_CHANNELS(N_CHANNELS)
    ) dut0 (
        .core_clock(core_clock),
        .reset(reset),
        .constant_valid(constant_valid),
        .constant_index(constant_index),
        .constant_data(constant_data),
        .sample_valid(sample_valid),
        .sample(sample),
        .start(start),
        .result_valid(result_valid),
        .result(result),
        .done(done)
    );

    initial begin
        core_clock = 1'b0;
        forever #20 core_clock = ~core_clock;
    end

    task automatic expect_true(input logic condition, input string what);
        checks++;
        assert (condition) else begin
            $display("Error at time %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic set_inputs(input logic cv, input fcore_pkg::const_index_t ci,
            input fcore_pkg::data_t cd, input logic sv, input fcore_pkg::reg_write_t sw,
            input logic st);
        constant_valid <= cv;
        constant_index <= ci;
        constant_data <= cd;
        sample_valid <= sv;
        sample <= sw;
        start <= st;
    endtask

    task automatic idle_cycle();
        @(posedge core_clock);
        set_inputs(1'b0, '0, '0, 1'b0, '0, 1'b0);
    endtask

    task automatic write_constant(input fcore_pkg::const_index_t ci, input fcore_pkg::data_t cd);
        @(posedge core_clock);
        set_inputs(1'b1, ci, cd, 1'b0, '0, 1'b0);
    endtask

    task automatic write_sample(input int ch, input fcore_pkg::data_t value);
        fcore_pkg::reg_write_t sw;
        sw.address = fcore_pkg::reg_addr_t'(ch);
        sw.data = value;
        @(posedge core_clock);
        set_inputs(1'b0, '0, '0, 1'b1, sw, 1'b0);
    endtask

    task automatic pulse_start();
        @(posedge core_clock);
        set_inputs(1'b0, '0, '0, 1'b0, '0, 1'b1);
    endtask

    // Half of the sample channels fall outside the channel range
    task automatic random_inputs(input logic allow_start);
        logic [2:0] kind;
        fcore_pkg::reg_write_t sw;
        kind = 3'(lfsr_bits(3));
        sw.address = fcore_pkg::reg_addr_t'(lfsr_bits(4));
        sw.data = fcore_pkg::data_t'(lfsr_bits(32));
        if (allow_start && kind == 3'd0) begin
            set_inputs(1'b0, '0, '0, 1'b0, '0, 1'b1);
        end else begin
            set_inputs(kind[0], fcore_pkg::const_index_t'(lfsr_bits(1)),
                fcore_pkg::data_t'(lfsr_bits(32)), kind[1], sw, 1'b0);
        end
    endtask

    task automatic wait_for_done();
        do begin
            idle_cycle();
        end while (!done);
    endtask

    // Traffic stops on the edge where done is seen, since the next edge finds the complex idle
    task automatic run_with_busy_traffic();
        logic finished;
        finished = 1'b0;
        pulse_start();
        while (!finished) begin
            @(posedge core_clock);
            if (done) begin
                set_inputs(1'b0, '0, '0, 1'b0, '0, 1'b0);
                finished = 1'b1;
            end else begin
                random_inputs(1'b1);
            end
        end
    endtask

    task automatic check_runs_closed(input int dones_before, input int runs);
        @(negedge core_clock);
        expect_true(dones_seen == dones_before + runs, "wrong number of done pulses");
        expect_true(expected_queue.size() == 0, "expected results were never delivered");
        expect_true(runs_pending == 0, "an accepted start did not end with done");
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_errors_start) begin
            $display("Test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: fail, %0d errors", tests_run, name, errors - test_errors_start);
        end
        test_errors_start = errors;
    endtask

    always @(posedge core_clock) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TB FAILED");
            $finish;
        end
    end

    // Outputs are checked before the model takes this edge's inputs
    always @(posedge core_clock) begin : monitor
        fcore_pkg::result_t expected;
        if (!reset) begin
            if (result_valid) begin
                results_seen++;
                expect_true(expected_queue.size() != 0,
                    $sformatf("result for channel %0d with no run in flight", result.channel));
                if (expected_queue.size() != 0) begin
                    expected = expected_queue.pop_front();
                    expect_true(result.channel == expected.channel, $sformatf(
                        "result channel %0d, expected %0d", result.channel, expected.channel));
                    expect_true(result.data == expected.data, $sformatf(
                        "channel %0d gave %0d, expected %0d",
                        result.channel, result.data, expected.data));
                end
            end
            if (done) begin
                dones_seen++;
                expect_true(runs_pending != 0 && expected_queue.size() == 0,
                    "done without a completed run");
                if (runs_pending != 0) begin
                    runs_pending--;
                end
            end
            model_clock_edge(constant_valid, constant_index, constant_data, sample_valid, sample,
                start, done);
        end
    end

    initial begin : main
        int dones_before;
        reset = 1'b1;
        set_inputs(1'b0, '0, '0, 1'b0, '0, 1'b0);
        repeat (5) @(posedge core_clock);
        reset <= 1'b0;

        write_constant(fcore_pkg::CONST_GAIN, fcore_pkg::data_t'(lfsr_bits(32)));
        pulse_start();
        repeat (60) idle_cycle();
        @(negedge core_clock);
        expect_true(results_seen == 0 && dones_seen == 0 && runs_accepted == 0,
            "a start before both constants were loaded began a run");
        finish_test("start before constants");

        dones_before = dones_seen;
        write_constant(fcore_pkg::CONST_GAIN, fcore_pkg::data_t'(lfsr_bits(32)));
        write_constant(fcore_pkg::CONST_OFFSET, fcore_pkg::data_t'(lfsr_bits(32)));
        for (int ch = 0; ch < N_CHANNELS; ch++) begin
            write_sample(ch, fcore_pkg::data_t'(lfsr_bits(32)));
        end
        pulse_start();
        wait_for_done();
        check_runs_closed(dones_before, 1);
        finish_test("basic run");

        dones_before = dones_seen;
        repeat (2) begin
            write_constant(fcore_pkg::CONST_OFFSET, fcore_pkg::data_t'(lfsr_bits(32)));
            write_constant(fcore_pkg::CONST_GAIN, fcore_pkg::data_t'(lfsr_bits(20)));
            pulse_start();
            wait_for_done();
        end
        check_runs_closed(dones_before, 2);
        finish_test("constants between runs");

        // Out of range writes come last so that an aliased slot would overwrite a fresh sample
        dones_before = dones_seen;
        for (int ch = 0; ch < N_CHANNELS / 2; ch++) begin
            write_sample(ch, fcore_pkg::data_t'(lfsr_bits(32)));
        end
        write_sample(N_CHANNELS, fcore_pkg::data_t'(lfsr_bits(32)));
        write_sample(N_CHANNELS + 1, fcore_pkg::data_t'(lfsr_bits(32)));
        write_sample(63, fcore_pkg::data_t'(lfsr_bits(32)));
        pulse_start();
        wait_for_done();
        check_runs_closed(dones_before, 1);
        finish_test("out of range samples");

        dones_before = dones_seen;
        repeat (3) run_with_busy_traffic();
        check_runs_closed(dones_before, 3);
        finish_test("writes during a run");

        dones_before = dones_seen;
        repeat (20) begin
            repeat (2 + int'(lfsr_bits(3))) begin
                @(posedge core_clock);
                random_inputs(1'b0);
            end
            run_with_busy_traffic();
        end
        check_runs_closed(dones_before, 20);
        finish_test("random soak");

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d results",
            tests_run, tests_failed, checks, errors, results_seen);
        if (errors == 0 && tests_failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- hdl/fcore_complex.sv
// Top level joining the input sequencer, register file and channel processor
`timescale 1ns/100ps

module fcore_complex #(
    // Channels plus the two constants must fit in the 64 register slots
    parameter int N_CHANNELS = 8
) (
    input logic core_clock,
    input logic reset,
    input logic constant_valid,
    input fcore_pkg::const_index_t constant_index,
    input fcore_pkg::data_t constant_data,
    input logic sample_valid,
    input fcore_pkg::reg_write_t sample,
    input logic start,
    output logic result_valid,
    output fcore_pkg::result_t result,
    output logic done
);

    logic write_valid;
    fcore_pkg::reg_write_t write;
    logic run;
    fcore_pkg::reg_addr_t read_address;
    fcore_pkg::data_t read_data;

    input_sequencer #(
        .N_CHANNELS(N_CHANNELS)
    ) sequencer (
        .core_clock(core_clock),
        .reset(reset),
        .constant_valid(constant_valid),
        .constant_index(constant_index),
        .constant_data(constant_data),
        .sample_valid(sample_valid),
        .sample(sample),
        .start(start),
        .done(done),
        .write_valid(write_valid),
        .write(write),
        .run(run)
    );

    register_file registers (
        .core_clock(core_clock),
        .reset(reset),
        .write_valid(write_valid),
        .write(write),
        .read_address(read_address),
        .read_data(read_data)
    );

    channel_processor #(
        .N_CHANNELS(N_CHANNELS)
    ) processor (
        .core_clock(core_clock),
        .reset(reset),
        .run(run),
        .read_data(read_data),
        .read_address(read_address),
        .result_valid(result_valid),
        .result(result),
        .done(done)
    );

endmodule

//--- hdl/channel_processor.sv
// Channel walker that applies gain and offset to every sample after a run pulse
`timescale 1ns/100ps

module channel_processor #(
    parameter int N_CHANNELS = 8
) (
    input logic core_clock,
    input logic reset,
    input logic run,
    input fcore_pkg::data_t read_data,
    output fcore_pkg::reg_addr_t read_address,
    output logic result_valid,
    output fcore_pkg::result_t result,
    output logic done
);

    localparam fcore_pkg::reg_addr_t GAIN_SLOT =
        fcore_pkg::reg_addr_t'(N_CHANNELS + fcore_pkg::CONST_GAIN);
    localparam fcore_pkg::reg_addr_t OFFSET_SLOT =
        fcore_pkg::reg_addr_t'(N_CHANNELS + fcore_pkg::CONST_OFFSET);
    localparam fcore_pkg::reg_addr_t LAST_CHANNEL = fcore_pkg::reg_addr_t'(N_CHANNELS - 1);

    typedef enum logic [2:0] {
        idle,
        load_gain,
        load_offset,
        read_sample,
        emit
    } processor_state_t;

    processor_state_t state;

    fcore_pkg::reg_addr_t channel;
    fcore_pkg::data_t gain;
    fcore_pkg::data_t offset;
    fcore_pkg::data_t scaled;
    logic signed [2*fcore_pkg::DATA_WIDTH-1:0] product;

    // Each state presents the address whose data the next state consumes
    always_comb begin
        case (state)
            load_gain: read_address = GAIN_SLOT;
            load_offset: read_address = OFFSET_SLOT;
            default: read_address = channel;
        endcase
    end

    assign product = read_data * gain;
    assign scaled = fcore_pkg::data_t'(product >>> fcore_pkg::FRACTION_BITS);

    always_ff @(posedge core_clock) begin
        if (reset) begin
            state <= idle;
            channel <= '0;
            result_valid <= 1'b0;
            done <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            done <= 1'b0;
            case (state)
                idle: begin
                    // A result seen here was the last one of the run
                    done <= result_valid;
                    if (run) begin
                        channel <= '0;
                        state <= load_gain;
                    end
                end
                load_gain: begin
                    state <= load_offset;
                end
                load_offset: begin
                    gain <= read_data;
                    state <= read_sample;
                end
                read_sample: begin
                    // Channel 0 directly follows load_offset, so the offset is on the bus
                    if (channel == '0) begin
                        offset <= read_data;
                    end
                    state <= emit;
                end
                emit: begin
                    result_valid <= 1'b1;
                    result.channel <= channel;
                    result.data <= scaled + offset;
                    if (channel == LAST_CHANNEL) begin
                        state <= idle;
                    end else begin
                        channel <= channel + 1'b1;
                        state <= read_sample;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

//--- hdl/register_file.sv
// Register array with one write port and one registered read port
`timescale 1ns/100ps

module register_file (
    input logic core_clock,
    input logic reset,
    input logic write_valid,
    input fcore_pkg::reg_write_t write,
    input fcore_pkg::reg_addr_t read_address,
    output fcore_pkg::data_t read_data
);

    localparam int DEPTH = 2 ** fcore_pkg::REG_ADDR_WIDTH;

    fcore_pkg::data_t slots [DEPTH];

    // Slots keep their value across runs until a new write hits them
    always_ff @(posedge core_clock) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                slots[i] <= '0;
            end
        end else if (write_valid) begin
            slots[write.address] <= write.data;
        end
    end

    // Read data follows the address by one cycle
    always_ff @(posedge core_clock) begin
        if (reset) begin
            read_data <= '0;
        end else begin
            read_data <= slots[read_address];
        end
    end

endmodule

//--- hdl/input_sequencer.sv
// Constant bank, sample write filter and start sequencing for the compute complex
`timescale 1ns/100ps

module input_sequencer #(
    parameter int N_CHANNELS = 8
) (
    input logic core_clock,
    input logic reset,
    input logic constant_valid,
    input fcore_pkg::const_index_t constant_index,
    input fcore_pkg::data_t constant_data,
    input logic sample_valid,
    input fcore_pkg::reg_write_t sample,
    input logic start,
    input logic done,
    output logic write_valid,
    output fcore_pkg::reg_write_t write,
    output logic run
);

    localparam fcore_pkg::reg_addr_t CHANNEL_LIMIT = fcore_pkg::reg_addr_t'(N_CHANNELS);
    localparam fcore_pkg::reg_addr_t GAIN_SLOT =
        fcore_pkg::reg_addr_t'(N_CHANNELS + fcore_pkg::CONST_GAIN);
    localparam int STEP_WIDTH = $clog2(fcore_pkg::N_CONSTANTS + 1);

    typedef enum logic [1:0] {
        wait_constants,
        idle,
        replay,
        busy
    } sequencer_state_t;

    sequencer_state_t state;

    fcore_pkg::data_t constants [fcore_pkg::N_CONSTANTS];
    logic [fcore_pkg::N_CONSTANTS-1:0] loaded;
    logic [fcore_pkg::N_CONSTANTS-1:0] loaded_next;
    logic [STEP_WIDTH-1:0] replay_step;

    always_comb begin
        loaded_next = loaded;
        if (constant_valid) begin
            loaded_next[constant_index] = 1'b1;
        end
    end

    always_ff @(posedge core_clock) begin
        if (reset) begin
            state <= wait_constants;
            loaded <= '0;
            replay_step <= '0;
            write_valid <= 1'b0;
            run <= 1'b0;
        end else begin
            write_valid <= 1'b0;
            run <= 1'b0;
            case (state)
                wait_constants, idle: begin
                    if (state == idle && start) begin
                        // The start owns the write port, so writes in the same cycle are lost
                        write_valid <= 1'b1;
                        write.address <= GAIN_SLOT;
                        write.data <= constants[fcore_pkg::CONST_GAIN];
                        replay_step <= STEP_WIDTH'(1);
                        state <= replay;
                    end else begin
                        if (constant_valid) begin
                            constants[constant_index] <= constant_data;
                        end
                        loaded <= loaded_next;
                        if (sample_valid && sample.address < CHANNEL_LIMIT) begin
                            write_valid <= 1'b1;
                            write <= sample;
                        end
                        // Leave the wait as soon as the last missing constant lands
                        if (&loaded_next) begin
                            state <= idle;
                        end
                    end
                end
                replay: begin
                    if (replay_step == STEP_WIDTH'(fcore_pkg::N_CONSTANTS)) begin
                        run <= 1'b1;
                        state <= busy;
                    end else begin
                        write_valid <= 1'b1;
                        write.address <= GAIN_SLOT + fcore_pkg::reg_addr_t'(replay_step);
                        write.data <= constants[fcore_pkg::const_index_t'(replay_step)];
                        replay_step <= replay_step + 1'b1;
                    end
                end
                busy: begin
                    if (done) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= wait_constants;
                end
            endcase
        end
    end

endmodule

//--- hdl/fcore_pkg.sv
// Widths, constant indices, vector types and bus structs shared by the compute complex

package fcore_pkg;

    // Sample, constant and result width
    parameter int DATA_WIDTH = 32;

    // Fixed-point fraction carried by the gain
    parameter int FRACTION_BITS = 16;

    // 64 slots hold the channels followed by the constants
    parameter int REG_ADDR_WIDTH = 6;

    parameter int N_CONSTANTS = 2;

    typedef logic signed [DATA_WIDTH-1:0] data_t;

    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

    typedef logic [0:0] const_index_t;

    // Positions of the constants in the bank and above the channel slots
    parameter const_index_t CONST_GAIN = 1'b0;
    parameter const_index_t CONST_OFFSET = 1'b1;

    typedef struct packed {
        reg_addr_t address;
        data_t data;
    } reg_write_t;

    typedef struct packed {
        reg_addr_t channel;
        data_t data;
    } result_t;

endpackage
